//--- include/fetch_macros.svh
// fetch-stage build constants
// queue depth must be a power of two, and the outstanding limit must not exceed it
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// address space
//////////////////////////////////////////////////////////////////////

// byte address width, trap vector layout assumes 32
`define FETCH_ADDR_W 32

//////////////////////////////////////////////////////////////////////
// prefetch sizing
//////////////////////////////////////////////////////////////////////

// instruction queue entries, 2 or 4
`define FETCH_QUEUE_DEPTH 2

// accepted bus requests still waiting for their response
`define FETCH_MAX_OUTSTANDING 2

`endif

//--- source/fetch_pkg.sv
// types shared by the fetch stage and its testbench
// struct widths follow FETCH_ADDR_W from the macro header
`include "fetch_macros.svh"

package fetch_pkg;

  // redirect source for the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_EXCEPTION = 3'd2,
    PC_IRQ       = 3'd3,
    PC_MRET      = 3'd4
  } pc_mux_e;

  // base opcodes produced by the compressed expander
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // instruction bus request, address held while ungranted
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] addr;
  } instr_req_t;

  // one response per accepted request, in order
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } instr_resp_t;

  // queue entry, fetch address and returned word
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [31:0]              word;
  } fetch_item_t;

  // IF/ID register as seen by decode
  typedef struct packed {
    logic                     instr_valid;
    logic [31:0]              instr;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     is_compressed;
    logic                     illegal_c_insn;
    logic [15:0]              compressed_instr;
  } if_id_pipe_t;

endpackage

//--- source/fetch_pc_select.sv
// redirect target selection, purely combinational
// jump and mepc targets are expected word aligned, only bit 0 is cleared here
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_pc_select (
  input  fetch_pkg::pc_mux_e        pc_mux_i,
  input  logic [`FETCH_ADDR_W-1:0]  boot_addr_i,
  input  logic [23:0]               mtvec_i,
  input  logic [4:0]                irq_id_i,
  input  logic [`FETCH_ADDR_W-1:0]  jump_target_i,
  input  logic [`FETCH_ADDR_W-1:0]  mepc_i,
  output logic [`FETCH_ADDR_W-1:0]  target_o
);
  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] trap_base;
  logic [`FETCH_ADDR_W-1:0] irq_offset;
  logic [`FETCH_ADDR_W-1:0] boot_aligned;

  // mtvec holds bits 31:8 of the trap table, table is 256 byte aligned
  assign trap_base = {mtvec_i, 8'h00};

  // vectored interrupts, one word per id
  assign irq_offset = `FETCH_ADDR_W'({irq_id_i, 2'b00});

  // boot address is forced to a word boundary
  assign boot_aligned = {boot_addr_i[`FETCH_ADDR_W-1:2], 2'b00};

  always_comb
  begin
    unique case (pc_mux_i)
      PC_BOOT:
        target_o = boot_aligned;
      PC_JUMP:
        target_o = {jump_target_i[`FETCH_ADDR_W-1:1], 1'b0};
      // all synchronous exceptions share the table base
      PC_EXCEPTION:
        target_o = trap_base;
      // no carry out of the low byte, ids stop at 31
      PC_IRQ:
        target_o = trap_base + irq_offset;
      PC_MRET:
        target_o = {mepc_i[`FETCH_ADDR_W-1:1], 1'b0};
      default:
        target_o = boot_aligned;
    endcase
  end

endmodule

//--- source/fetch_prefetch_buffer.sv
// request issue and in-order instruction queue, one instruction per 32-bit word
// a redirect withdraws any ungranted request, the new address shows one cycle later
// fetch address resets to 0, the top forces a boot redirect right after reset
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_prefetch_buffer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_i,
  input  logic                      redirect_i,
  input  logic [`FETCH_ADDR_W-1:0]  redirect_addr_i,
  output fetch_pkg::instr_req_t     instr_req_o,
  input  logic                      instr_gnt_i,
  input  fetch_pkg::instr_resp_t    instr_resp_i,
  output logic                      head_valid_o,
  output fetch_pkg::fetch_item_t    head_o,
  input  logic                      pop_i,
  output logic                      busy_o
);
  import fetch_pkg::*;

  localparam int unsigned DEPTH   = `FETCH_QUEUE_DEPTH;
  localparam int unsigned MAX_OUT = `FETCH_MAX_OUTSTANDING;
  localparam int unsigned PTR_W   = $clog2(DEPTH);
  localparam int unsigned CNT_W   = $clog2(DEPTH + 1);
  localparam int unsigned OUT_W   = $clog2(MAX_OUT + 1);

  // queue storage, slots between alloc and fill wait for their word
  fetch_item_t              queue_q [DEPTH];
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [PTR_W-1:0]         fill_ptr_q;
  logic [PTR_W-1:0]         alloc_ptr_q;
  logic [CNT_W-1:0]         occ_q;

  // in-flight bookkeeping
  logic [OUT_W-1:0]         out_q;
  logic [OUT_W-1:0]         out_next;
  logic [OUT_W-1:0]         discard_q;
  logic [`FETCH_ADDR_W-1:0] fetch_addr_q;

  logic                     room;
  logic                     req_valid;
  logic                     accept;
  logic                     resp_keep;
  logic                     resp_drop;

  //////////////////////////////////////////////////////////////////////
  // bus request side
  //////////////////////////////////////////////////////////////////////

  // every in-flight request may still need a queue slot
  assign room = (int'(out_q) + int'(occ_q) < DEPTH) && (int'(out_q) < MAX_OUT);

  assign req_valid         = req_i && room && !redirect_i;
  assign instr_req_o.valid = req_valid;
  assign instr_req_o.addr  = fetch_addr_q;
  assign accept            = req_valid && instr_gnt_i;

  // responses to requests from before a redirect are dropped
  assign resp_drop = instr_resp_i.rvalid && (discard_q != '0);
  assign resp_keep = instr_resp_i.rvalid && (discard_q == '0);

  assign out_next = out_q + OUT_W'(accept) - OUT_W'(instr_resp_i.rvalid);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q <= '0;
      out_q        <= '0;
      discard_q    <= '0;
      rd_ptr_q     <= '0;
      fill_ptr_q   <= '0;
      alloc_ptr_q  <= '0;
      occ_q        <= '0;
    end
    else
    begin
      out_q <= out_next;
      if (redirect_i)
      begin
        // everything still in flight belongs to the old stream
        fetch_addr_q <= redirect_addr_i;
        discard_q    <= out_next;
        rd_ptr_q     <= '0;
        fill_ptr_q   <= '0;
        alloc_ptr_q  <= '0;
        occ_q        <= '0;
      end
      else
      begin
        if (accept)
        begin
          fetch_addr_q <= fetch_addr_q + `FETCH_ADDR_W'(4);
          alloc_ptr_q  <= alloc_ptr_q + 1'b1;
        end
        if (resp_drop)
        begin
          discard_q <= discard_q - 1'b1;
        end
        if (resp_keep)
        begin
          fill_ptr_q <= fill_ptr_q + 1'b1;
        end
        if (pop_i)
        begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        occ_q <= occ_q + CNT_W'(resp_keep) - CNT_W'(pop_i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // queue storage
  //////////////////////////////////////////////////////////////////////

  // address reserved at grant, word filled in on response
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      queue_q[alloc_ptr_q].addr <= fetch_addr_q;
    end
    if (resp_keep && !redirect_i)
    begin
      queue_q[fill_ptr_q].word <= instr_resp_i.rdata;
    end
  end

  // head is hidden during the flush cycle
  assign head_valid_o = (occ_q != '0) && !redirect_i;
  assign head_o       = queue_q[rd_ptr_q];
  assign busy_o       = (out_q != '0);

  // top only pops what is offered
  a_pop_has_head: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> head_valid_o)
    else $error("pop without a valid queue head");

  a_out_limit: assert property (@(posedge clk) disable iff (!rst_n)
    int'(out_q) <= MAX_OUT)
    else $error("outstanding requests above limit");

  // the bus never answers a request that was not accepted
  a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    instr_resp_i.rvalid |-> (out_q != '0))
    else $error("response with no request outstanding");

endmodule

//--- source/fetch_compressed_decoder.sv
// RV32C expansion for c.addi, c.li, c.mv, c.add, c.j, c.lw and c.sw
// every other compressed encoding is flagged illegal
`timescale 1ns/1ps

module fetch_compressed_decoder (
  input  logic [31:0] word_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);
  import fetch_pkg::*;

  logic [2:0] funct3;
  logic [4:0] rd;
  logic [4:0] rs2;
  logic [4:0] rdp;
  logic [4:0] rs1p;

  // compressed register fields map onto x8..x15
  assign funct3 = word_i[15:13];
  assign rd     = word_i[11:7];
  assign rs2    = word_i[6:2];
  assign rdp    = {2'b01, word_i[4:2]};
  assign rs1p   = {2'b01, word_i[9:7]};

  assign is_compressed_o = (word_i[1:0] != 2'b11);

  always_comb
  begin
    // full-width words pass through untouched
    instr_o   = word_i;
    illegal_o = 1'b0;
    if (is_compressed_o)
    begin
      illegal_o = 1'b1;
      unique case (word_i[1:0])
        // quadrant 0, loads and stores
        2'b00:
        begin
          if (funct3 == 3'b010)
          begin
            // c.lw, offset scaled by 4
            instr_o = {5'b0, word_i[5], word_i[12:10], word_i[6], 2'b00,
                       rs1p, 3'b010, rdp, OPC_LOAD};
            illegal_o = 1'b0;
          end
          else if (funct3 == 3'b110)
          begin
            // c.sw, rs2' sits where rd' does for c.lw
            instr_o = {5'b0, word_i[5], word_i[12], rdp, rs1p, 3'b010,
                       word_i[11:10], word_i[6], 2'b00, OPC_STORE};
            illegal_o = 1'b0;
          end
        end
        // quadrant 1, immediates and jumps
        2'b01:
        begin
          if (funct3 == 3'b000)
          begin
            // c.addi, sign-extended 6 bit immediate
            instr_o = {{6{word_i[12]}}, word_i[12], word_i[6:2], rd, 3'b000, rd, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
          else if (funct3 == 3'b010)
          begin
            // c.li as addi rd, x0, imm
            instr_o = {{6{word_i[12]}}, word_i[12], word_i[6:2], 5'b0, 3'b000, rd, OPC_OP_IMM};
            illegal_o = 1'b0;
          end
          else if (funct3 == 3'b101)
          begin
            // c.j as jal x0, offset bits reshuffled into J layout
            instr_o = {word_i[12], word_i[8], word_i[10:9], word_i[6], word_i[7],
                       word_i[2], word_i[11], word_i[5:3], word_i[12],
                       {8{word_i[12]}}, 5'b0, OPC_JAL};
            illegal_o = 1'b0;
          end
        end
        // quadrant 2, only the register moves and adds
        2'b10:
        begin
          // rs2 of zero would be c.jr, c.jalr or c.ebreak
          if ((funct3 == 3'b100) && (rs2 != 5'b0))
          begin
            if (!word_i[12])
            begin
              instr_o = {7'b0, rs2, 5'b0, 3'b000, rd, OPC_OP};
            end
            else
            begin
              instr_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
            end
            illegal_o = 1'b0;
          end
        end
        default:
        begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- source/fetch_if_stage.sv
// instruction fetch stage top, a boot redirect is taken in the first cycle after reset
// redirect targets must be word aligned since fetch always steps by 4
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_if_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_i,
  input  logic [`FETCH_ADDR_W-1:0]  boot_addr_i,
  input  logic [23:0]               mtvec_i,
  input  logic [4:0]                irq_id_i,
  input  logic                      pc_set_i,
  input  fetch_pkg::pc_mux_e        pc_mux_i,
  input  logic [`FETCH_ADDR_W-1:0]  jump_target_i,
  input  logic [`FETCH_ADDR_W-1:0]  mepc_i,
  input  logic                      id_ready_i,
  input  logic                      clear_instr_valid_i,
  output fetch_pkg::instr_req_t     instr_req_o,
  input  logic                      instr_gnt_i,
  input  fetch_pkg::instr_resp_t    instr_resp_i,
  output fetch_pkg::if_id_pipe_t    if_id_o,
  output logic                      mtvec_init_o,
  output logic                      busy_o,
  output logic                      imiss_o
);
  import fetch_pkg::*;

  logic                     boot_q;
  logic                     redirect;
  pc_mux_e                  pc_sel;
  logic [`FETCH_ADDR_W-1:0] target;
  logic                     head_valid;
  fetch_item_t              head;
  logic                     if_valid;
  logic [31:0]              dec_instr;
  logic                     dec_compressed;
  logic                     dec_illegal;

  // one-shot boot redirect out of reset, an explicit pc_set wins
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      boot_q <= 1'b1;
    end
    else
    begin
      boot_q <= 1'b0;
    end
  end

  assign redirect = pc_set_i || boot_q;
  assign pc_sel   = pc_set_i ? pc_mux_i : PC_BOOT;

  // csr file loads its mtvec default on boot
  assign mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  fetch_pc_select u_pc_select (
    .pc_mux_i      (pc_sel),
    .boot_addr_i   (boot_addr_i),
    .mtvec_i       (mtvec_i),
    .irq_id_i      (irq_id_i),
    .jump_target_i (jump_target_i),
    .mepc_i        (mepc_i),
    .target_o      (target)
  );

  fetch_prefetch_buffer u_prefetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .redirect_i      (redirect),
    .redirect_addr_i (target),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_resp_i    (instr_resp_i),
    .head_valid_o    (head_valid),
    .head_o          (head),
    .pop_i           (if_valid),
    .busy_o          (busy_o)
  );

  fetch_compressed_decoder u_c_decoder (
    .word_i          (head.word),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_o       (dec_illegal)
  );

  // head moves into decode whenever decode can take it
  assign if_valid = head_valid && id_ready_i;

  // decode ready but nothing to hand over
  assign imiss_o = id_ready_i && !redirect && !head_valid;

  //////////////////////////////////////////////////////////////////////
  // IF/ID register, frozen while decode stalls
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      if_id_o <= '0;
    end
    else if (if_valid)
    begin
      if_id_o.instr_valid      <= 1'b1;
      if_id_o.instr            <= dec_instr;
      if_id_o.pc               <= head.addr;
      if_id_o.is_compressed    <= dec_compressed;
      if_id_o.illegal_c_insn   <= dec_illegal;
      if_id_o.compressed_instr <= head.word[15:0];
    end
    else if (clear_instr_valid_i)
    begin
      if_id_o.instr_valid <= 1'b0;
    end
  end

  // pc comes from redirect targets plus 4 steps, so misalignment means a bad target
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_o.instr_valid |-> (if_id_o.pc[1:0] == 2'b00))
    else $error("IF/ID pc not word aligned");

endmodule

//--- sim/fetch_tb.sv
// fetch stage testbench with random bus timing, stalls and redirects, seed 17
// memory is 256 words and aliases above 1 KiB; redirect operands are kept word aligned
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int RST_CYC   = 10;
  localparam int LEN_SEQ   = 400;
  localparam int LEN_REDIR = 600;
  localparam int LEN_STALL = 400;
  localparam int LEN_CTRL  = 300;
  // every test plus reset and a margin, at 40 ns per cycle
  localparam int BUDGET_NS = (RST_CYC + LEN_SEQ + LEN_REDIR + LEN_STALL + LEN_CTRL + 200) * 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_i;
  logic [31:0] boot_addr_i;
  logic [23:0] mtvec_i;
  logic [4:0]  irq_id_i;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  logic [31:0] jump_target_i;
  logic [31:0] mepc_i;
  logic        id_ready_i;
  logic        clear_instr_valid_i;
  instr_req_t  instr_req_o;
  logic        instr_gnt_i;
  instr_resp_t instr_resp_i;
  if_id_pipe_t if_id_o;
  logic        mtvec_init_o;
  logic        busy_o;
  logic        imiss_o;

  // run control and counters
  logic [31:0] mem [256];
  string       cur_test = "reset";
  int          ready_pct = 0;
  int          redir_pct = 0;
  int          clear_pct = 0;
  int          errors = 0;
  int          checks = 0;
  int          loads = 0;
  int          redirects = 0;
  // kinds 0..6 are the expanded opcodes, 7 illegal, 8 full width
  int          kind_seen [9];
  int          mux_seen [5];

  // reference model state
  if_id_pipe_t exp_ifid;
  logic [31:0] exp_pc;
  logic        boot_pending = 1'b1;
  logic        first_after = 1'b0;
  int          last_mux = 0;
  int          tb_out = 0;
  // words waiting in the queue, and old-stream responses still to drop
  int          tb_occ = 0;
  int          tb_discard = 0;

  // bus responder state
  logic        accepted = 1'b0;
  logic [31:0] acc_addr;
  logic [31:0] resp_addr_q [$];
  int          resp_due_q [$];
  int          cyc = 0;

  fetch_if_stage uut (.*);

  initial
  begin
    forever
    begin
      #20 clk = ~clk;
    end
  end

  initial
  begin
    #(BUDGET_NS);
    $display("watchdog: run did not finish within %0d ns", BUDGET_NS);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // model functions
  //////////////////////////////////////////////////////////////////////

  // RV32C expansion written from the spec field layouts
  function automatic logic [31:0] expand_c(input logic [15:0] c, output int kind);
    logic [11:0] imm6;
    logic [11:0] off_w;
    logic [20:0] off_j;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdc;
    logic [4:0]  rs1c;
    rd    = c[11:7];
    rs2   = c[6:2];
    rdc   = {2'b01, c[4:2]};
    rs1c  = {2'b01, c[9:7]};
    imm6  = {{7{c[12]}}, c[6:2]};
    off_w = {5'b0, c[5], c[12:10], c[6], 2'b00};
    off_j = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    kind = 7;
    expand_c = 32'h0;
    case ({c[15:13], c[1:0]})
      5'b000_01:
      begin
        kind = 0;
        expand_c = {imm6, rd, 3'b000, rd, 7'h13};
      end
      5'b010_01:
      begin
        kind = 1;
        expand_c = {imm6, 5'd0, 3'b000, rd, 7'h13};
      end
      5'b100_10:
      begin
        // rs2 of x0 belongs to jr, jalr and ebreak
        if (rs2 != 5'd0)
        begin
          kind = c[12] ? 3 : 2;
          expand_c = {7'b0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, 7'h33};
        end
      end
      5'b101_01:
      begin
        kind = 4;
        expand_c = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], 5'd0, 7'h6f};
      end
      5'b010_00:
      begin
        kind = 5;
        expand_c = {off_w, rs1c, 3'b010, rdc, 7'h03};
      end
      5'b110_00:
      begin
        kind = 6;
        expand_c = {off_w[11:5], rdc, rs1c, 3'b010, off_w[4:0], 7'h23};
      end
      default:
      begin
        kind = 7;
      end
    endcase
  endfunction

  // redirect target from the current operand inputs
  function automatic logic [31:0] model_target(input pc_mux_e sel);
    logic [31:0] base;
    base = {mtvec_i, 8'h00};
    case (sel)
      PC_BOOT:      model_target = boot_addr_i & 32'hffff_fffc;
      PC_JUMP:      model_target = jump_target_i & 32'hffff_fffe;
      PC_EXCEPTION: model_target = base;
      PC_IRQ:       model_target = base + {25'd0, irq_id_i, 2'b00};
      default:      model_target = mepc_i & 32'hffff_fffe;
    endcase
  endfunction

  // memory word, a mix of the seven opcodes, other compressed and full width
  function automatic logic [31:0] make_word();
    logic [31:0] w;
    w = $urandom;
    case ($urandom % 10)
      0: w = {w[31:16], 3'b000, w[12:2], 2'b01};
      1: w = {w[31:16], 3'b010, w[12:2], 2'b01};
      2: w = {w[31:16], 4'b1000, w[11:3], 1'b1, 2'b10};
      3: w = {w[31:16], 4'b1001, w[11:3], 1'b1, 2'b10};
      4: w = {w[31:16], 3'b101, w[12:2], 2'b01};
      5: w = {w[31:16], 3'b010, w[12:2], 2'b00};
      6: w = {w[31:16], 3'b110, w[12:2], 2'b00};
      7: w[1:0] = 2'($urandom % 3);
      default: w[1:0] = 2'b11;
    endcase
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and bus responder, driven on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    id_ready_i          <= ($urandom % 100) < ready_pct;
    req_i               <= ($urandom % 100) < 95;
    pc_set_i            <= ($urandom % 100) < redir_pct;
    pc_mux_i            <= pc_mux_e'($urandom % 5);
    boot_addr_i         <= $urandom;
    mtvec_i             <= 24'($urandom);
    irq_id_i            <= 5'($urandom);
    jump_target_i       <= $urandom & 32'hffff_fffc;
    mepc_i              <= $urandom & 32'hffff_fffc;
    clear_instr_valid_i <= ($urandom % 100) < clear_pct;
  end

  // in-order responses, each 1 to 4 cycles after its grant
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    instr_gnt_i <= ($urandom % 4) != 0;
    if (accepted)
    begin
      resp_addr_q.push_back(acc_addr);
      resp_due_q.push_back(cyc + 1 + int'($urandom % 4));
    end
    if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cyc))
    begin
      instr_resp_i.rvalid <= 1'b1;
      instr_resp_i.rdata  <= mem[resp_addr_q[0][9:2]];
      resp_addr_q.delete(0);
      resp_due_q.delete(0);
    end
    else
    begin
      instr_resp_i.rvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // monitor on the falling edge, where inputs and outputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin : monitor
    logic        redirect_now;
    logic        load;
    logic [31:0] word;
    int          kind;
    if (rst_n === 1'b0)
    begin
      check_value("reset req valid", 32'd0, instr_req_o.valid);
      check_value("reset instr_valid", 32'd0, if_id_o.instr_valid);
      check_value("reset busy", 32'd0, busy_o);
      check_value("reset mtvec_init", 32'd0, mtvec_init_o);
      check_value("reset imiss", 32'd0, imiss_o);
      exp_ifid     = '0;
      tb_out       = 0;
      tb_occ       = 0;
      tb_discard   = 0;
      boot_pending = 1'b1;
      accepted     = 1'b0;
    end
    else if (rst_n === 1'b1)
    begin
      // outcome of the last rising edge
      check_value("instr_valid", exp_ifid.instr_valid, if_id_o.instr_valid);
      if (exp_ifid.instr_valid)
      begin
        check_value("pc", exp_ifid.pc, if_id_o.pc);
        check_value("is_compressed", exp_ifid.is_compressed, if_id_o.is_compressed);
        check_value("illegal_c_insn", exp_ifid.illegal_c_insn, if_id_o.illegal_c_insn);
        check_value("compressed_instr", exp_ifid.compressed_instr, if_id_o.compressed_instr);
        if (!exp_ifid.illegal_c_insn)
        begin
          check_value("instr", exp_ifid.instr, if_id_o.instr);
        end
      end
      check_value("busy", tb_out != 0, busy_o);
      check_value("mtvec_init", pc_set_i && (pc_mux_i == PC_BOOT), mtvec_init_o);

      // first cycle out of reset takes the boot redirect
      redirect_now = pc_set_i || boot_pending;
      if (redirect_now)
      begin
        exp_pc       = pc_set_i ? model_target(pc_mux_i) : (boot_addr_i & 32'hffff_fffc);
        last_mux     = pc_set_i ? int'(pc_mux_i) : int'(PC_BOOT);
        first_after  = 1'b1;
        boot_pending = 1'b0;
        redirects++;
      end

      // decode ready with an empty queue is a miss
      check_value("imiss", id_ready_i && !redirect_now && (tb_occ == 0), imiss_o);

      // decode ready, no redirect and a queued word means the head moves in
      load = id_ready_i && !redirect_now && (tb_occ != 0);
      if (load)
      begin
        word = mem[exp_pc[9:2]];
        exp_ifid.instr_valid      = 1'b1;
        exp_ifid.pc               = exp_pc;
        exp_ifid.compressed_instr = word[15:0];
        exp_ifid.is_compressed    = (word[1:0] != 2'b11);
        if (exp_ifid.is_compressed)
        begin
          exp_ifid.instr = expand_c(word[15:0], kind);
        end
        else
        begin
          exp_ifid.instr = word;
          kind = 8;
        end
        exp_ifid.illegal_c_insn = (kind == 7);
        kind_seen[kind]++;
        if (first_after)
        begin
          mux_seen[last_mux]++;
          first_after = 1'b0;
        end
        exp_pc = exp_pc + 32'd4;
        loads++;
      end
      else if (clear_instr_valid_i)
      begin
        exp_ifid.instr_valid = 1'b0;
      end

      // bus traffic the next edge will see
      accepted = instr_req_o.valid && instr_gnt_i;
      acc_addr = instr_req_o.addr;
      tb_out   = tb_out + int'(accepted) - int'(instr_resp_i.rvalid);
      if (tb_out > `FETCH_MAX_OUTSTANDING)
      begin
        errors++;
        $display("%s: %0d requests outstanding on the bus, more than allowed", cur_test, tb_out);
      end

      // queue fill, whatever is still in flight at a redirect is dropped
      if (redirect_now)
      begin
        tb_occ     = 0;
        tb_discard = tb_out;
      end
      else
      begin
        if (instr_resp_i.rvalid && (tb_discard > 0))
        begin
          tb_discard--;
        end
        else if (instr_resp_i.rvalid)
        begin
          tb_occ++;
        end
        if (load)
        begin
          tb_occ--;
        end
      end
    end
  end

  task automatic run_test(input string name, input int len, input int rdy, input int redir,
                          input int clr);
    int err_start;
    int load_start;
    int redir_start;
    err_start   = errors;
    load_start  = loads;
    redir_start = redirects;
    cur_test    = name;
    ready_pct   = rdy;
    redir_pct   = redir;
    clear_pct   = clr;
    repeat (len) @(negedge clk);
    #1;
    if (loads == load_start)
    begin
      errors++;
      $display("%s: no instruction reached decode", name);
    end
    $display("test %-10s %0d loads, %0d redirects, %0d errors", name, loads - load_start,
             redirects - redir_start, errors - err_start);
  endtask

  initial
  begin : main_flow
    pc_mux_e     sel;
    void'($urandom(17));
    rst_n               <= 1'b0;
    req_i               <= 1'b0;
    boot_addr_i         <= 32'h0000_1003;
    mtvec_i             <= 24'h000010;
    irq_id_i            <= 5'd0;
    pc_set_i            <= 1'b0;
    pc_mux_i            <= PC_BOOT;
    jump_target_i       <= 32'h0;
    mepc_i              <= 32'h0;
    id_ready_i          <= 1'b0;
    clear_instr_valid_i <= 1'b0;
    instr_gnt_i         <= 1'b0;
    instr_resp_i        <= '0;
    for (int i = 0; i < 256; i++)
    begin
      mem[i] = make_word();
    end
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    #1;

    // name, cycles, ready %, redirect %, clear %
    run_test("sequential", LEN_SEQ, 90, 0, 0);
    run_test("redirect", LEN_REDIR, 75, 6, 0);
    run_test("stall", LEN_STALL, 20, 2, 0);
    run_test("control", LEN_CTRL, 70, 5, 30);

    for (int k = 0; k < 8; k++)
    begin
      if (kind_seen[k] == 0)
      begin
        errors++;
        $display("compressed kind %0d never reached decode", k);
      end
    end
    for (int m = 0; m < 5; m++)
    begin
      sel = pc_mux_e'(m);
      if (mux_seen[m] == 0)
      begin
        errors++;
        $display("no redirect from %s was followed by a fetch", sel.name());
      end
    end
    $display("done: %0d checks, %0d loads, %0d errors", checks, loads, errors);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- fetch_if_stage.f
+incdir+include
source/fetch_pkg.sv
source/fetch_pc_select.sv
source/fetch_prefetch_buffer.sv
source/fetch_compressed_decoder.sv
source/fetch_if_stage.sv
sim/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch stage testbench

SRCS := $(shell grep -v '^+' fetch_if_stage.f)

# rebuilt only when a source, the header or the file list changes
obj_dir/Vfetch_tb: fetch_if_stage.f $(SRCS) include/fetch_macros.svh
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
		-f fetch_if_stage.f -Mdir obj_dir

# the run fails on a simulator error or when the log holds the fail message
run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
